//--- Makefile
SIM ?= verilator
FLAGS ?= --binary --timing --assert -j 0
TOP ?= dmem_tb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir

BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) dmem_settings.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation finished: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

//--- bank_if.sv
// request and response bundle between the router and one data memory bank
`timescale 1ns/1ps

interface bank_if
(
	input logic clock,
	input logic reset
);

	// request side, driven by the router as plain levels
	// the op level is the request itself and stays steady until the bank answers
	mem_ctrl_pkg::access_op_t op;
	mem_geom_pkg::bank_addr_t addr;
	mem_geom_pkg::dblock_t wdata;

	// response side, registered inside the bank
	// ready answers a read, done answers a write
	logic ready;
	logic done;
	mem_geom_pkg::dblock_t rdata;

	// the router also sees the clock and reset so it can check the two banks against each other
	modport router
	(
		input clock,
		input reset,
		output op,
		output addr,
		output wdata,
		input ready,
		input done,
		input rdata
	);

	// the bank takes its clock and reset through its own ports
	modport bank
	(
		input op,
		input addr,
		input wdata,
		output ready,
		output done,
		output rdata
	);

endinterface

//--- dmem_bank.sv
// one data memory bank with latency counter, write capture and registered read-out
`timescale 1ns/1ps
`include "dmem_settings.svh"

module dmem_bank
(
	input logic clock,
	input logic reset,
	bank_if.bank port
);

	localparam int bank_depth = 2 ** `DMEM_BANK_ADDR_BITS;

	// value the counter takes at the first edge of an access, that edge already counts
	localparam logic [`DMEM_DELAY_CNTR_BITS-1:0] cntr_first =
		{{(`DMEM_DELAY_CNTR_BITS-1){1'b0}}, 1'b1};

	// storage is kept as words so each word of a block can be written on its own lane
	mem_geom_pkg::dword_t mem [bank_depth][`DMEM_BLOCK_WORDS];

	logic [`DMEM_DELAY_CNTR_BITS-1:0] delay_cntr;
	mem_ctrl_pkg::bank_state_t state;
	mem_ctrl_pkg::access_op_t cur_op;
	mem_geom_pkg::dblock_t wr_block;
	mem_geom_pkg::dblock_t rd_block;
	logic active;
	logic restart;
	logic delayed;
	logic read_fire;
	logic write_fire;
	logic write_commit;

	// only reads and writes count as work, idle and conflict both clear the bank
	assign active = (port.op == mem_ctrl_pkg::op_read) || (port.op == mem_ctrl_pkg::op_write);

	// a fresh access starts from idle, or when the op switches to the other kind mid-way
	assign restart = active && ((state == mem_ctrl_pkg::st_idle) || (port.op != cur_op));

	// the latency is over once the counter sits at all ones
	// a restart edge is always the first edge of a new wait, whatever the old count was
	assign delayed = (&delay_cntr) && !restart;

	assign read_fire = delayed && (port.op == mem_ctrl_pkg::op_read);
	assign write_fire = delayed && (port.op == mem_ctrl_pkg::op_write);

	// the block goes into memory once, at the edge that ends the wait
	assign write_commit = write_fire && (state == mem_ctrl_pkg::st_wait);

	// gather the addressed block, word 0 into the low bits
	always_comb
	begin
		for (int i = 0; i < `DMEM_BLOCK_WORDS; i++)
		begin
			rd_block[i*`DMEM_WORD_BITS +: `DMEM_WORD_BITS] = mem[port.addr][i];
		end
	end

	// FSM and latency counter
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			state <= mem_ctrl_pkg::st_idle;
			cur_op <= mem_ctrl_pkg::op_idle;
			delay_cntr <= '0;
		end
		else if (!active)
		begin
			// dropping the op aborts or ends the access
			state <= mem_ctrl_pkg::st_idle;
			cur_op <= mem_ctrl_pkg::op_idle;
			delay_cntr <= '0;
		end
		else if (restart)
		begin
			state <= mem_ctrl_pkg::st_wait;
			cur_op <= port.op;
			delay_cntr <= cntr_first;
		end
		else
		begin
			// count up and hold at the top value
			if (!delayed)
			begin
				delay_cntr <= delay_cntr + 1'b1;
			end
			if ((state == mem_ctrl_pkg::st_wait) && delayed)
			begin
				state <= mem_ctrl_pkg::st_ready;
			end
		end
	end

	// write data is taken at the first edge of a write, later changes of wdata are ignored
	always_ff @(posedge clock)
	begin
		if (restart && (port.op == mem_ctrl_pkg::op_write))
		begin
			wr_block <= port.wdata;
		end
	end

	always_ff @(posedge clock)
	begin
		if (write_commit)
		begin
			for (int i = 0; i < `DMEM_BLOCK_WORDS; i++)
			begin
				mem[port.addr][i] <= wr_block[i*`DMEM_WORD_BITS +: `DMEM_WORD_BITS];
			end
		end
	end

	// response registers
	// a held read reloads rdata every edge from the address sampled at that edge
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			port.ready <= 1'b0;
			port.done <= 1'b0;
			port.rdata <= '0;
		end
		else
		begin
			port.ready <= read_fire;
			port.done <= write_fire;
			port.rdata <= read_fire ? rd_block : '0;
		end
	end

	// the router turns a conflict into idle, so it must never arrive here
	a_no_conflict_op: assert property (@(posedge clock) disable iff (!reset)
		port.op != mem_ctrl_pkg::op_conflict)
		else $error("bank received op_conflict");

	a_ready_done_excl: assert property (@(posedge clock) disable iff (!reset)
		!(port.ready && port.done))
		else $error("bank raised ready and done together");

	// read data must never leak out while no read result is being presented
	a_rdata_quiet: assert property (@(posedge clock) disable iff (!reset)
		!port.ready |-> (port.rdata == '0))
		else $error("bank rdata not zero while ready is low");

endmodule

//--- dmem_bank_router.sv
// request decode, bank steering and response merge for the two interleaved banks
`timescale 1ns/1ps
`include "dmem_settings.svh"

module dmem_bank_router
(
	input logic ren,
	input logic wen,
	input mem_geom_pkg::block_addr_t block_address,
	input mem_geom_pkg::dblock_t din,
	output logic ready,
	output logic done,
	output logic conflict,
	output mem_geom_pkg::dblock_t dout,
	bank_if.router bank0,
	bank_if.router bank1
);

	mem_ctrl_pkg::access_op_t req_op;
	mem_ctrl_pkg::access_op_t bank_op;
	logic bank_sel;
	mem_geom_pkg::bank_addr_t bank_index;

	// decode the two request levels into one opcode
	always_comb
	begin
		case ({ren, wen})
			2'b10: req_op = mem_ctrl_pkg::op_read;
			2'b01: req_op = mem_ctrl_pkg::op_write;
			2'b11: req_op = mem_ctrl_pkg::op_conflict;
			default: req_op = mem_ctrl_pkg::op_idle;
		endcase
	end

	// an illegal request is flagged at once and blocked from both banks
	assign conflict = (req_op == mem_ctrl_pkg::op_conflict);
	assign bank_op = conflict ? mem_ctrl_pkg::op_idle : req_op;

	// blocks interleave on the lowest address bit, the rest indexes inside the bank
	assign bank_sel = block_address[0];
	assign bank_index = block_address[`DMEM_BLOCK_ADDR_BITS-1:1];

	// the bank that is not addressed sees idle and clears itself
	assign bank0.op = bank_sel ? mem_ctrl_pkg::op_idle : bank_op;
	assign bank1.op = bank_sel ? bank_op : mem_ctrl_pkg::op_idle;

	// address and write data can go to both banks, only the selected one acts on them
	assign bank0.addr = bank_index;
	assign bank1.addr = bank_index;
	assign bank0.wdata = din;
	assign bank1.wdata = din;

	// an unselected bank holds its status low, so an OR merges the two cleanly
	assign ready = bank0.ready | bank1.ready;
	assign done = bank0.done | bank1.done;

	// read data follows the bank bit of the current address
	assign dout = bank_sel ? bank1.rdata : bank0.rdata;

	// only one bank is ever addressed, so at most one of them may be answering
	// a switch of bank lets the old one clear at the next edge while the new one still waits
	a_single_bank_busy: assert property (@(posedge bank0.clock) disable iff (!bank0.reset)
		!((bank0.ready || bank0.done) && (bank1.ready || bank1.done)))
		else $error("both banks reported a result in the same cycle");

endmodule

//--- dmem_settings.svh
// data memory geometry and latency settings shared by the packages and the RTL
`ifndef DMEM_SETTINGS_SVH
`define DMEM_SETTINGS_SVH

// width of one data word in bits
`define DMEM_WORD_BITS 32

// a block is the unit of every access, four words wide
`define DMEM_BLOCK_WORDS 4

// block address seen at the top level, 32 blocks in total
`define DMEM_BLOCK_ADDR_BITS 5

// the lowest block address bit picks the bank, so each bank sees one bit less
`define DMEM_BANK_ADDR_BITS (`DMEM_BLOCK_ADDR_BITS - 1)

// the latency counter saturates at all ones, which gives 2**bits edges of delay
`define DMEM_DELAY_CNTR_BITS 2

// full block width in bits
`define DMEM_BLOCK_BITS (`DMEM_WORD_BITS * `DMEM_BLOCK_WORDS)

`endif

//--- dmem_tb.sv
// testbench for the two-bank data memory with a reference model and assertion checkers
`timescale 1ns/1ps
`include "dmem_settings.svh"

module dmem_tb;

	localparam int latency = 2 ** `DMEM_DELAY_CNTR_BITS;
	localparam int clock_period_ns = 8;
	localparam int planned_accesses = 30;
	localparam int watchdog_ns = planned_accesses * (latency + 4) * clock_period_ns + 1000;
	localparam int wait_limit = 4 * latency;

	logic clock;
	logic reset;
	logic ren = 1'b0;
	logic wen = 1'b0;
	mem_geom_pkg::block_addr_t block_address = '0;
	mem_geom_pkg::dblock_t din = '0;
	logic ready;
	logic done;
	logic conflict;
	mem_geom_pkg::dblock_t dout;

	int errors = 0;
	int seed = 56042;

	// reference state, updated at each edge from the levels sampled at that edge
	mem_geom_pkg::dblock_t model [2 ** `DMEM_BLOCK_ADDR_BITS];
	mem_geom_pkg::dblock_t wr_cap = '0;
	mem_ctrl_pkg::access_op_t last_op = mem_ctrl_pkg::op_idle;
	logic last_bank = 1'b0;
	int edge_cnt = 0;
	logic exp_ready = 1'b0;
	logic exp_done = 1'b0;
	mem_geom_pkg::dblock_t exp_dout = '0;

	tb_clock_gen clock_gen
	(
		.clock(clock),
		.reset(reset)
	);

	dmem_top UUT
	(
		.clock(clock),
		.reset(reset),
		.ren(ren),
		.wen(wen),
		.block_address(block_address),
		.din(din),
		.ready(ready),
		.done(done),
		.conflict(conflict),
		.dout(dout)
	);

	function automatic mem_ctrl_pkg::access_op_t decode_op(input logic r, input logic w);
		if (r && w)
			return mem_ctrl_pkg::op_conflict;
		else if (r)
			return mem_ctrl_pkg::op_read;
		else if (w)
			return mem_ctrl_pkg::op_write;
		return mem_ctrl_pkg::op_idle;
	endfunction

	function automatic mem_geom_pkg::dblock_t random_block();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	// expected outputs after each edge
	// an access restarts when its kind or its bank changes, and it answers on the latency-th edge
	always @(posedge clock or negedge reset)
	begin : reference_model
		mem_ctrl_pkg::access_op_t kind;
		mem_geom_pkg::dblock_t blk;
		logic fresh;
		int cnt;
		if (!reset)
		begin
			edge_cnt <= 0;
			last_op <= mem_ctrl_pkg::op_idle;
			exp_ready <= 1'b0;
			exp_done <= 1'b0;
			exp_dout <= '0;
		end
		else
		begin
			kind = decode_op(ren, wen);
			if ((kind == mem_ctrl_pkg::op_read) || (kind == mem_ctrl_pkg::op_write))
			begin
				fresh = (kind != last_op) || (block_address[0] != last_bank);
				if (fresh)
				begin
					// write data counts only at the first edge of the write
					cnt = 1;
					blk = din;
					wr_cap <= din;
				end
				else
				begin
					cnt = (edge_cnt < latency) ? edge_cnt + 1 : edge_cnt;
					blk = wr_cap;
				end
				exp_ready <= (kind == mem_ctrl_pkg::op_read) && (cnt == latency);
				exp_done <= (kind == mem_ctrl_pkg::op_write) && (cnt == latency);
				exp_dout <= ((kind == mem_ctrl_pkg::op_read) && (cnt == latency)) ?
					model[block_address] : '0;
				// the block lands in memory once, when the wait first runs out
				if ((kind == mem_ctrl_pkg::op_write) && (cnt == latency) &&
					(fresh || (edge_cnt < latency)))
				begin
					model[block_address] <= blk;
				end
				edge_cnt <= cnt;
				last_op <= kind;
				last_bank <= block_address[0];
			end
			else
			begin
				// idle and conflict both clear the access
				edge_cnt <= 0;
				last_op <= mem_ctrl_pkg::op_idle;
				exp_ready <= 1'b0;
				exp_done <= 1'b0;
				exp_dout <= '0;
			end
		end
	end

	chk_ready: assert property (@(posedge clock) ready == exp_ready)
		else
		begin
			errors++;
			$display("ERR %0t ready expected %0b actual %0b", $time, $sampled(exp_ready),
				$sampled(ready));
		end

	chk_done: assert property (@(posedge clock) done == exp_done)
		else
		begin
			errors++;
			$display("ERR %0t done expected %0b actual %0b", $time, $sampled(exp_done),
				$sampled(done));
		end

	chk_dout: assert property (@(posedge clock) dout == exp_dout)
		else
		begin
			errors++;
			$display("ERR %0t dout expected %h actual %h", $time, $sampled(exp_dout),
				$sampled(dout));
		end

	// conflict is combinational, so it follows ren and wen in the same cycle
	chk_conflict: assert property (@(posedge clock) conflict == (ren && wen))
		else
		begin
			errors++;
			$display("ERR %0t conflict expected %0b actual %0b", $time, $sampled(ren && wen),
				$sampled(conflict));
		end

	chk_reset_quiet: assert property (@(posedge clock)
		!reset |-> (!ready && !done && !conflict && (dout == '0)))
		else
		begin
			errors++;
			$display("outputs were not all zero while reset was asserted at %0t", $time);
		end

	// a conflict held for a second cycle must have kept both banks from answering
	chk_conflict_blocks: assert property (@(posedge clock) disable iff (!reset)
		($past(conflict) && conflict) |-> (!ready && !done))
		else
		begin
			errors++;
			$display("a result came out during a held conflict at %0t", $time);
		end

	// outputs are looked at on the falling edge, well away from the drive edge
	task automatic wait_result(input logic for_write);
		int n;
		n = 0;
		while (n < wait_limit)
		begin
			@(negedge clock);
			if (for_write ? done : ready)
				break;
			n++;
		end
		if (n == wait_limit)
		begin
			errors++;
			$display("%s never rose within %0d cycles at %0t", for_write ? "done" : "ready",
				wait_limit, $time);
		end
	endtask

	task automatic write_block(input mem_geom_pkg::block_addr_t addr,
		input mem_geom_pkg::dblock_t blk, input logic scramble);
		@(posedge clock);
		wen <= 1'b1;
		block_address <= addr;
		din <= blk;
		if (scramble)
		begin
			// the next edge captures blk, so anything driven after it must be ignored
			@(posedge clock);
			din <= ~blk;
		end
		wait_result(1'b1);
		@(posedge clock);
		@(posedge clock);
		wen <= 1'b0;
		din <= '0;
	endtask

	task automatic read_block(input mem_geom_pkg::block_addr_t addr);
		@(posedge clock);
		ren <= 1'b1;
		block_address <= addr;
		wait_result(1'b0);
		@(posedge clock);
		@(posedge clock);
		ren <= 1'b0;
	endtask

	// all addresses stay in one bank, so ready is expected to stay high throughout
	task automatic held_read(input mem_geom_pkg::block_addr_t seq [5]);
		@(posedge clock);
		ren <= 1'b1;
		block_address <= seq[0];
		wait_result(1'b0);
		for (int i = 1; i < 5; i++)
		begin
			@(posedge clock);
			block_address <= seq[i];
		end
		@(posedge clock);
		@(posedge clock);
		ren <= 1'b0;
	endtask

	task automatic conflict_burst(input mem_geom_pkg::block_addr_t addr, input int cycles);
		@(posedge clock);
		ren <= 1'b1;
		wen <= 1'b1;
		block_address <= addr;
		din <= random_block();
		repeat (cycles) @(posedge clock);
		ren <= 1'b0;
		wen <= 1'b0;
		din <= '0;
	endtask

	initial
	begin : stimulus
		mem_geom_pkg::block_addr_t pair_base [4];
		mem_geom_pkg::block_addr_t even_seq [5];
		mem_geom_pkg::block_addr_t odd_seq [5];
		pair_base = '{5'd4, 5'd12, 5'd22, 5'd30};
		even_seq = '{5'd4, 5'd12, 5'd22, 5'd30, 5'd4};
		odd_seq = '{5'd5, 5'd13, 5'd23, 5'd31, 5'd13};
		@(posedge reset);
		@(posedge clock);
		// even and odd neighbours share their upper bits and differ only in the bank
		foreach (pair_base[i])
		begin
			write_block(pair_base[i], random_block(), 1'b0);
			write_block(pair_base[i] | 5'd1, random_block(), 1'b0);
		end
		foreach (pair_base[i])
		begin
			read_block(pair_base[i] | 5'd1);
			read_block(pair_base[i]);
		end
		held_read(even_seq);
		held_read(odd_seq);
		// din flips right after the capture edge
		write_block(5'd12, random_block(), 1'b1);
		read_block(5'd12);
		// memory behind a blocked request must be untouched
		// the conflict outlasts the latency, so a request that slipped through would complete
		conflict_burst(5'd22, latency + 2);
		read_block(5'd22);
		repeat (4) @(posedge clock);
		$display("run complete with %0d errors", errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin : watchdog
		#(watchdog_ns);
		$display("watchdog expired after %0d ns before the tests completed", watchdog_ns);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- dmem_top.sv
// two-bank block data memory with plain request and result ports
`timescale 1ns/1ps

module dmem_top
(
	input logic clock,
	input logic reset,
	input logic ren,
	input logic wen,
	input mem_geom_pkg::block_addr_t block_address,
	input mem_geom_pkg::dblock_t din,
	output logic ready,
	output logic done,
	output logic conflict,
	output mem_geom_pkg::dblock_t dout
);

	// one bundle per bank, the clock and reset ride along for the router checks
	bank_if bank0_if
	(
		.clock(clock),
		.reset(reset)
	);

	bank_if bank1_if
	(
		.clock(clock),
		.reset(reset)
	);

	// the router is purely combinational, so the bank latency is the full top latency
	dmem_bank_router router
	(
		.ren(ren),
		.wen(wen),
		.block_address(block_address),
		.din(din),
		.ready(ready),
		.done(done),
		.conflict(conflict),
		.dout(dout),
		.bank0(bank0_if.router),
		.bank1(bank1_if.router)
	);

	// even block addresses
	dmem_bank bank0
	(
		.clock(clock),
		.reset(reset),
		.port(bank0_if.bank)
	);

	// odd block addresses
	dmem_bank bank1
	(
		.clock(clock),
		.reset(reset),
		.port(bank1_if.bank)
	);

endmodule

//--- mem_ctrl_pkg.sv
// control encodings for the data memory, decoded request opcodes and bank states
package mem_ctrl_pkg;

	// request kind decoded from the ren and wen levels
	// op_conflict marks ren and wen high together and never reaches a bank
	typedef enum logic [1:0]
	{
		op_idle = 2'd0,
		op_read = 2'd1,
		op_write = 2'd2,
		op_conflict = 2'd3
	} access_op_t;

	// bank sequencing
	// st_wait counts out the access latency
	// st_ready holds the result level while the request is kept up
	typedef enum logic [1:0]
	{
		st_idle = 2'd0,
		st_wait = 2'd1,
		st_ready = 2'd2
	} bank_state_t;

endpackage

//--- mem_geom_pkg.sv
// data types describing the word, block and address geometry of the data memory
`include "dmem_settings.svh"

package mem_geom_pkg;

	// one data word as stored in a bank
	typedef logic [`DMEM_WORD_BITS-1:0] dword_t;

	// one block, flat and packed
	// word 0 sits in the lowest bits, word n starts at bit n times the word width
	typedef logic [`DMEM_BLOCK_BITS-1:0] dblock_t;

	// block address as the core presents it at the top level
	// bit 0 is the bank select, the upper bits index inside the bank
	typedef logic [`DMEM_BLOCK_ADDR_BITS-1:0] block_addr_t;

	// block index inside one bank, the top address without its bank bit
	typedef logic [`DMEM_BANK_ADDR_BITS-1:0] bank_addr_t;

endpackage

//--- tb.f
+incdir+.
mem_geom_pkg.sv
mem_ctrl_pkg.sv
bank_if.sv
dmem_bank.sv
dmem_bank_router.sv
dmem_top.sv
tb_clock_gen.sv
dmem_tb.sv

//--- tb_clock_gen.sv
// testbench clock and reset source, 8 ns clock and a reset held low for three cycles
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic clock,
	output logic reset
);

	localparam int half_period_ns = 4;
	localparam int reset_cycles = 3;

	initial
	begin
		clock = 1'b0;
		forever #(half_period_ns) clock = ~clock;
	end

	// reset is active low and lets go on a rising edge, like every other driven input
	initial
	begin
		reset = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b1;
	end

endmodule
